/* memArbPkg.sv */
package memArbPkg;

	// **************************************************
	// sizes of the shared RAM subsystem
	// **************************************************

	// cores sharing the RAM.
	localparam int NCORES = 4;

	// one byte lane per core on each bus.
	localparam int ADDR_W = 8;
	localparam int DATA_W = 8;

	// every byte address is backed.
	localparam int RAM_DEPTH = 1 << ADDR_W;

	// **************************************************
	// core index
	// **************************************************

	// arbiter pointer, mux select and return tag.
	typedef logic [$clog2(NCORES)-1:0] coreIdx_t;

endpackage

/* memArbiter.sv */
`timescale 1ns/100ps

module memArbiter import memArbPkg::*; (
	input  logic              clk,
	input  logic              rstN,
	input  logic [NCORES-1:0] rden,
	input  logic [NCORES-1:0] wren,
	output logic [NCORES-1:0] grant,
	output coreIdx_t          sel,
	output logic              selValid
);

	// **************************************************
	// state
	// **************************************************

	// search starts after the last core granted.
	coreIdx_t ptr;

	logic [NCORES-1:0] avail;
	logic [NCORES-1:0] nextGrant;
	coreIdx_t          nextIdx;
	logic              nextFound;

	// a core granted now may not be granted again next cycle.
	assign avail = (rden | wren) & ~grant;

	// **************************************************
	// round-robin search
	// **************************************************

	// first requester after the pointer wins.
	always_comb begin
		coreIdx_t cand;

		cand      = ptr;
		nextIdx   = ptr;
		nextFound = 1'b0;
		for (int off = 1; off <= NCORES; off++) begin
			cand = ptr + coreIdx_t'(off); // wraps around.
			if (!nextFound && avail[cand]) begin
				nextIdx   = cand;
				nextFound = 1'b1;
			end
		end
	end

	always_comb begin
		nextGrant = '0;
		if (nextFound) begin
			nextGrant[nextIdx] = 1'b1;
		end
	end

	// **************************************************
	// registered grant
	// **************************************************

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			grant    <= '0;
			sel      <= '0;
			selValid <= 1'b0;
			ptr      <= coreIdx_t'(NCORES - 1); // core 0 searched first.
		end else begin
			grant    <= nextGrant; // one-cycle pulse.
			sel      <= nextIdx;
			selValid <= nextFound;
			if (nextFound) begin
				ptr <= nextIdx;
			end
		end
	end

endmodule

/* coreRequestMux.sv */
`timescale 1ns/100ps

module coreRequestMux import memArbPkg::*; (
	input  coreIdx_t                   sel,
	input  logic                       selValid,
	input  logic [NCORES-1:0]          rden,
	input  logic [NCORES-1:0]          wren,
	input  logic [NCORES*ADDR_W-1:0]   coreAddr,
	input  logic [NCORES*DATA_W-1:0]   coreWdata,
	output logic [ADDR_W-1:0]          ramAddr,
	output logic [DATA_W-1:0]          ramWdata,
	output logic                       ramWe,
	output logic                       isRead
);

	// strobes of the granted core.
	logic laneRd;
	logic laneWr;

	// **************************************************
	// lane select
	// **************************************************

	// address and data need no qualifier.
	always_comb begin
		ramAddr  = coreAddr[sel*ADDR_W +: ADDR_W];
		ramWdata = coreWdata[sel*DATA_W +: DATA_W];
	end

	assign laneRd = rden[sel];
	assign laneWr = wren[sel];

	// **************************************************
	// qualifiers
	// **************************************************

	// only in a grant cycle.
	assign ramWe = selValid & laneWr;

	// read and write together counts as a write.
	assign isRead = selValid & laneRd & ~laneWr;

endmodule

/* sharedRam.sv */
`timescale 1ns/100ps

module sharedRam import memArbPkg::*; (
	input  logic              clk,
	input  logic [ADDR_W-1:0] ramAddr,
	input  logic [DATA_W-1:0] ramWdata,
	input  logic              ramWe,
	output logic [DATA_W-1:0] ramQ
);

	// **************************************************
	// storage
	// **************************************************

	logic [DATA_W-1:0] mem [RAM_DEPTH];

	// write at the end of the grant cycle.
	always_ff @(posedge clk) begin
		if (ramWe) begin
			mem[ramAddr] <= ramWdata;
		end
	end

	// registered read, valid the cycle after the grant.
	always_ff @(posedge clk) begin
		ramQ <= mem[ramAddr];
	end

endmodule

/* readReturn.sv */
`timescale 1ns/100ps

module readReturn import memArbPkg::*; (
	input  logic                     clk,
	input  logic                     rstN,
	input  logic                     isRead,
	input  coreIdx_t                 sel,
	input  logic [DATA_W-1:0]        ramQ,
	output logic [NCORES*DATA_W-1:0] rdData,
	output logic [NCORES-1:0]        rdValid
);

	// **************************************************
	// pending read
	// **************************************************

	// one read in the RAM pipe, tagged with its core.
	logic     pendRead;
	coreIdx_t pendTag;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pendRead <= 1'b0;
			pendTag  <= '0;
		end else begin
			pendRead <= isRead;
			pendTag  <= sel;
		end
	end

	// **************************************************
	// lane update
	// **************************************************

	// ramQ is valid now; hand it to the tagged lane.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rdData  <= '0;
			rdValid <= '0;
		end else begin
			for (int i = 0; i < NCORES; i++) begin
				rdValid[i] <= pendRead && (pendTag == coreIdx_t'(i)); // pulse.
				if (pendRead && (pendTag == coreIdx_t'(i))) begin
					rdData[i*DATA_W +: DATA_W] <= ramQ;
				end
			end
		end
	end

endmodule

/* multiCoreMemSystem.sv */
`timescale 1ns/100ps

module multiCoreMemSystem import memArbPkg::*; (
	input  logic                     clk,
	input  logic                     rstN,
	input  logic [NCORES-1:0]        rden,
	input  logic [NCORES-1:0]        wren,
	input  logic [NCORES*ADDR_W-1:0] coreAddr,
	input  logic [NCORES*DATA_W-1:0] coreWdata,
	output logic [NCORES-1:0]        grant,
	output logic [NCORES*DATA_W-1:0] rdData,
	output logic [NCORES-1:0]        rdValid
);

	// **************************************************
	// internal wires
	// **************************************************

	coreIdx_t          sel;
	logic              selValid;
	logic [ADDR_W-1:0] ramAddr;
	logic [DATA_W-1:0] ramWdata;
	logic              ramWe;
	logic              isRead;
	logic [DATA_W-1:0] ramQ;

	// **************************************************
	// control
	// **************************************************

	memArbiter u_memArbiter (
		.clk      (clk),
		.rstN     (rstN),
		.rden     (rden),
		.wren     (wren),
		.grant    (grant),
		.sel      (sel),
		.selValid (selValid)
	);

	// **************************************************
	// datapath
	// **************************************************

	coreRequestMux u_coreRequestMux (
		.sel       (sel),
		.selValid  (selValid),
		.rden      (rden),
		.wren      (wren),
		.coreAddr  (coreAddr),
		.coreWdata (coreWdata),
		.ramAddr   (ramAddr),
		.ramWdata  (ramWdata),
		.ramWe     (ramWe),
		.isRead    (isRead)
	);

	sharedRam u_sharedRam (
		.clk      (clk),
		.ramAddr  (ramAddr),
		.ramWdata (ramWdata),
		.ramWe    (ramWe),
		.ramQ     (ramQ)
	);

	// back to the requesting core, two cycles after grant.
	readReturn u_readReturn (
		.clk     (clk),
		.rstN    (rstN),
		.isRead  (isRead),
		.sel     (sel),
		.ramQ    (ramQ),
		.rdData  (rdData),
		.rdValid (rdValid)
	);

endmodule

/* multiCoreMemSystem_props.sv */
`timescale 1ns/100ps

module multiCoreMemSystem_props import memArbPkg::*; (
	input logic              clk,
	input logic              rstN,
	input logic [NCORES-1:0] rden,
	input logic [NCORES-1:0] wren,
	input logic [NCORES-1:0] grant,
	input logic [NCORES-1:0] rdValid
);

	// **************************************************
	// grant rules
	// **************************************************

	grantOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(grant))
		else $error("grant not one-hot: %b", grant);

	// strobes were sampled at the edge that raised grant.
	grantHadRequest: assert property (@(posedge clk) disable iff (!rstN)
		(grant != '0) |-> ((grant & $past(rden | wren)) == grant))
		else $error("grant %b to a core that was not requesting", grant);

	noBackToBack: assert property (@(posedge clk) disable iff (!rstN)
		(grant & $past(grant)) == '0)
		else $error("core granted in two consecutive cycles: %b", grant);

	// **************************************************
	// return path
	// **************************************************

	rdValidOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(rdValid))
		else $error("rdValid not one-hot: %b", rdValid);

endmodule

// grant and return checks on the top-level ports.
bind multiCoreMemSystem multiCoreMemSystem_props u_props (
	.clk     (clk),
	.rstN    (rstN),
	.rden    (rden),
	.wren    (wren),
	.grant   (grant),
	.rdValid (rdValid)
);

/* tb_multiCoreMemSystem.sv */
`timescale 1ns/100ps

module tb_multiCoreMemSystem import memArbPkg::*; ();

	localparam int N_SINGLE = 16;
	localparam int N_FAIR = 8; // rounds per core.
	localparam int N_RAND = 40;
	localparam int N_BOTH = 4;
	localparam int N_TOTAL = 2 * N_SINGLE + RAM_DEPTH + NCORES * N_FAIR
		+ NCORES * N_RAND + 2 * N_BOTH;
	localparam int CYCLE_LIMIT = 4 * N_TOTAL + 200;

	logic                     clk = 1'b0;
	logic                     rstN = 1'b0;
	logic [NCORES-1:0]        rden = '0;
	logic [NCORES-1:0]        wren = '0;
	logic [NCORES*ADDR_W-1:0] coreAddr = '0;
	logic [NCORES*DATA_W-1:0] coreWdata = '0;
	logic [NCORES-1:0]        grant;
	logic [NCORES*DATA_W-1:0] rdData;
	logic [NCORES-1:0]        rdValid;

	// **************************************************
	// core models and reference memory
	// **************************************************

	// request word is {kind, idle, addr, data}; kind bit 0 reads and bit 1 writes.
	logic [19:0]              planQ [NCORES][$];
	logic [19:0]              curReq [NCORES];
	int                       expT [NCORES][$]; // return cycle.
	logic [7:0]               expB [NCORES][$];
	logic [NCORES-1:0]        busy = '0;
	logic [NCORES-1:0]        dropNext = '0;
	int                       idleCnt [NCORES] = '{default: 0};
	int                       waitGrants [NCORES] = '{default: 0};
	logic [7:0]               refMem [RAM_DEPTH];
	logic [NCORES*DATA_W-1:0] prevData = '0;
	logic                     checkRot = 1'b0;
	logic                     rotValid = 1'b0;
	int                       lastIdx = 0;
	logic [31:0]              seed;
	int                       cycle = 0;
	int                       errors = 0;
	int                       testsRun = 0;
	int                       testsFailed = 0;

	multiCoreMemSystem u_multiCoreMemSystem (
		.clk       (clk),
		.rstN      (rstN),
		.rden      (rden),
		.wren      (wren),
		.coreAddr  (coreAddr),
		.coreWdata (coreWdata),
		.grant     (grant),
		.rdData    (rdData),
		.rdValid   (rdValid)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("timeout: traffic not finished after %0d cycles", CYCLE_LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] randWord();
		logic [31:0] x;
		x = seed;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		seed = x;
		return x;
	endfunction

	function automatic logic [19:0] packReq(input logic [1:0] kind, input logic [1:0] idle,
			input logic [7:0] addr, input logic [7:0] data);
		return {kind, idle, addr, data};
	endfunction

	task automatic checkQuiet();
		if (grant != '0) begin
			$display("** Error at %0t: grant = %b, expected 0", $time, grant);
			errors++;
		end
		if (rdValid != '0) begin
			$display("** Error at %0t: rdValid = %b, expected 0", $time, rdValid);
			errors++;
		end
	endtask

	task automatic checkReturn(input int i);
		int         t;
		logic [7:0] b;
		logic [7:0] lane;
		lane = rdData[i*DATA_W +: DATA_W];
		if (rdValid[i]) begin
			if (expT[i].size() == 0) begin
				$display("at %0t: core %0d got rdValid with no read pending", $time, i);
				errors++;
			end else begin
				t = expT[i].pop_front();
				b = expB[i].pop_front();
				if (t != cycle) begin
					$display("** Error at %0t: rdValid[%0d] cycle = %0d, expected %0d",
						$time, i, cycle, t);
					errors++;
				end
				if (lane != b) begin
					$display("** Error at %0t: rdData lane %0d = %h, expected %h",
						$time, i, lane, b);
					errors++;
				end
			end
		end else begin
			if (lane != prevData[i*DATA_W +: DATA_W]) begin
				$display("** Error at %0t: rdData lane %0d = %h, expected %h",
					$time, i, lane, prevData[i*DATA_W +: DATA_W]);
				errors++;
			end
			if (expT[i].size() != 0 && expT[i][0] < cycle) begin
				$display("at %0t: read return for core %0d never came", $time, i);
				errors++;
				void'(expT[i].pop_front());
				void'(expB[i].pop_front());
			end
		end
	endtask

	task automatic checkGrant(input int i);
		logic [7:0] addr;
		if (!busy[i] || dropNext[i]) begin
			$display("at %0t: core %0d granted with no request pending", $time, i);
			errors++;
		end else begin
			addr = curReq[i][15:8];
			if (waitGrants[i] > NCORES - 1) begin
				$display("at %0t: core %0d waited through %0d other grants",
					$time, i, waitGrants[i]);
				errors++;
			end
			if (curReq[i][19]) begin
				refMem[addr] = curReq[i][7:0]; // write wins over read.
			end else begin
				expT[i].push_back(cycle + 2);
				expB[i].push_back(refMem[addr]);
			end
			dropNext[i] = 1'b1;
		end
		if (checkRot && rotValid && i != (lastIdx + 1) % NCORES) begin
			$display("** Error at %0t: grant = %b, expected core %0d",
				$time, grant, (lastIdx + 1) % NCORES);
			errors++;
		end
		lastIdx = i;
		rotValid = 1'b1;
		for (int j = 0; j < NCORES; j++) begin
			if (j != i && busy[j] && !dropNext[j]) begin
				waitGrants[j]++;
			end
		end
	endtask

	// hold strobes through the grant cycle, drop them one cycle later.
	task automatic stepCore(input int i);
		logic [19:0] req;
		if (dropNext[i] && !grant[i]) begin
			rden[i] = 1'b0;
			wren[i] = 1'b0;
			busy[i] = 1'b0;
			dropNext[i] = 1'b0;
			idleCnt[i] = int'(curReq[i][17:16]);
		end else if (!busy[i] && idleCnt[i] > 0) begin
			idleCnt[i]--;
		end else if (!busy[i] && planQ[i].size() > 0) begin
			req = planQ[i].pop_front();
			curReq[i] = req;
			rden[i] = req[18];
			wren[i] = req[19];
			coreAddr[i*ADDR_W +: ADDR_W] = req[15:8];
			coreWdata[i*DATA_W +: DATA_W] = req[7:0];
			busy[i] = 1'b1;
			waitGrants[i] = 0;
		end
	endtask

	always @(negedge clk) begin
		if (!rstN) begin
			checkQuiet();
		end else begin
			for (int i = 0; i < NCORES; i++) begin
				checkReturn(i);
			end
			for (int i = 0; i < NCORES; i++) begin
				if (grant[i]) begin
					checkGrant(i);
				end
			end
			for (int i = 0; i < NCORES; i++) begin
				stepCore(i);
			end
			prevData = rdData;
		end
	end

	task automatic waitDrain();
		logic quiet;
		quiet = 1'b0;
		while (!quiet) begin
			@(negedge clk);
			quiet = 1'b1;
			for (int i = 0; i < NCORES; i++) begin
				if (planQ[i].size() != 0 || busy[i] || idleCnt[i] != 0
						|| expT[i].size() != 0) begin
					quiet = 1'b0;
				end
			end
		end
	endtask

	task automatic finishTest(input string name, input int errBase);
		testsRun++;
		if (errors == errBase) begin
			$display("test %s: passed", name);
		end else begin
			testsFailed++;
			$display("test %s: failed with %0d errors", name, errors - errBase);
		end
	endtask

	// **************************************************
	// test sequence
	// **************************************************

	initial begin
		int          errBase;
		logic [31:0] r;
		$timeformat(-9, 1, " ns", 0);
		seed = 32'ha3123599;

		errBase = errors;
		repeat (8) @(negedge clk);
		rstN = 1'b1;
		repeat (2) begin
			@(negedge clk);
			checkQuiet();
		end
		finishTest("reset state", errBase);

		errBase = errors;
		for (int k = 0; k < N_SINGLE; k++) begin
			r = randWord();
			planQ[0].push_back(packReq(2'd2, 2'd0, 8'(k * 17), r[7:0]));
		end
		waitDrain();
		for (int k = 0; k < N_SINGLE; k++) begin
			planQ[0].push_back(packReq(2'd1, 2'd0, 8'(k * 17), 8'd0));
		end
		waitDrain();
		finishTest("single core write then read", errBase);

		// every address gets a known byte.
		errBase = errors;
		for (int a = 0; a < RAM_DEPTH; a++) begin
			r = randWord();
			planQ[a % NCORES].push_back(packReq(2'd2, 2'd0, 8'(a), r[7:0]));
		end
		waitDrain();
		finishTest("memory fill", errBase);

		errBase = errors;
		checkRot = 1'b1;
		rotValid = 1'b0;
		for (int k = 0; k < N_FAIR; k++) begin
			for (int i = 0; i < NCORES; i++) begin
				r = randWord();
				planQ[i].push_back(packReq(2'd1, 2'd0, r[7:0], 8'd0));
			end
		end
		waitDrain();
		checkRot = 1'b0;
		finishTest("round-robin fairness", errBase);

		errBase = errors;
		for (int i = 0; i < NCORES; i++) begin
			for (int k = 0; k < N_RAND; k++) begin
				r = randWord();
				planQ[i].push_back(packReq(r[0] ? 2'd2 : 2'd1, r[3:2], r[15:8], r[23:16]));
			end
		end
		waitDrain();
		finishTest("random mixed traffic", errBase);

		errBase = errors;
		for (int k = 0; k < N_BOTH; k++) begin
			r = randWord();
			planQ[2].push_back(packReq(2'd3, 2'd0, r[7:0], r[15:8]));
			planQ[2].push_back(packReq(2'd1, 2'd1, r[7:0], 8'd0));
		end
		waitDrain();
		finishTest("read and write together", errBase);

		$display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
		if (testsFailed == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* tb.f */
memArbPkg.sv
memArbiter.sv
coreRequestMux.sv
sharedRam.sv
readReturn.sv
multiCoreMemSystem.sv
multiCoreMemSystem_props.sv
tb_multiCoreMemSystem.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_multiCoreMemSystem

out=$(./obj_dir/Vtb_multiCoreMemSystem)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
exit 1
